// File: include/id_remap_defines.svh
`ifndef ID_REMAP_DEFINES_SVH
`define ID_REMAP_DEFINES_SVH

// ******************************
// Table geometry
// ******************************

// Number of remap slots.
`define ID_REMAP_SLOTS   64

// Outgoing ID, one slot number.
`define ID_REMAP_SLOT_W  6

// Incoming transaction ID.
`define ID_REMAP_ORIG_W  8

// Live-slot count, wide enough to hold 64.
`define ID_REMAP_OCC_W   7

`endif

// File: verilog/id_remap_pkg.sv
`default_nettype none

`include "id_remap_defines.svh"

package id_remap_pkg;

  typedef logic [`ID_REMAP_SLOT_W-1:0] slot_t;    // Narrow outgoing ID.
  typedef logic [`ID_REMAP_ORIG_W-1:0] orig_id_t; // Wide incoming ID.
  typedef logic [`ID_REMAP_OCC_W-1:0]  occ_t;

  // Allocation handshake states.
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    ACK  = 2'd1,
    DROP = 2'd2
  } alloc_state_t;

endpackage

`default_nettype wire

// File: verilog/slot_alloc_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module slot_alloc_fsm (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                alloc_req_i,
  input  logic                full_i,
  input  id_remap_pkg::slot_t free_slot_i,
  output logic                grant_o,
  output logic                alloc_ack_o,
  output id_remap_pkg::slot_t alloc_slot_o
);

  import id_remap_pkg::*;

  alloc_state_t state_q;
  alloc_state_t state_d;

  // One grant per request, held off while the table is full.
  assign grant_o = (state_q == IDLE) && alloc_req_i && !full_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (grant_o) state_d = ACK;
      ACK:
        if (!alloc_req_i) state_d = DROP; // Requester has let go.
      DROP:
        state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= IDLE;
      alloc_ack_o <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (grant_o)
        alloc_ack_o <= 1'b1;
      else if (state_q == DROP)
        alloc_ack_o <= 1'b0;      // Ack falls one edge after req seen low.
    end
  end

  // Slot captured with the grant, stable for the whole ack phase.
  always_ff @(posedge clk)
  begin
    if (grant_o)
      alloc_slot_o <= free_slot_i;
  end

endmodule

`default_nettype wire

// File: verilog/slot_bitmap.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_remap_defines.svh"

module slot_bitmap (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                set_i,
  input  id_remap_pkg::slot_t set_slot_i,
  input  logic                release_i,
  input  id_remap_pkg::slot_t release_slot_i,
  output id_remap_pkg::slot_t free_slot_o,
  output logic                release_hit_o
);

  import id_remap_pkg::*;

  logic [`ID_REMAP_SLOTS-1:0] valid_q;

  // ******************************
  // Valid map update
  // ******************************

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_q <= '0;
    end
    else
    begin
      if (release_i)
        valid_q[release_slot_i] <= 1'b0;
      // Later assignment, so set wins on the same bit.
      if (set_i)
        valid_q[set_slot_i] <= 1'b1;
    end
  end

  assign release_hit_o = valid_q[release_slot_i];

  // ******************************
  // Lowest free slot
  // ******************************

  // Scan from the top so the lowest clear bit is the last one kept.
  always_comb
  begin
    free_slot_o = '0;
    for (int i = `ID_REMAP_SLOTS - 1; i >= 0; i--)
    begin
      if (!valid_q[i])
        free_slot_o = slot_t'(i);
    end
  end

endmodule

`default_nettype wire

// File: verilog/occupancy_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_remap_defines.svh"

module occupancy_counter (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               inc_i,
  input  logic               dec_i,
  output id_remap_pkg::occ_t occupancy_o,
  output logic               full_o,
  output logic               empty_o
);

  import id_remap_pkg::*;

  occ_t occ_d;

  always_comb
  begin
    occ_d = occupancy_o;
    if (inc_i && !dec_i)
      occ_d = occupancy_o + occ_t'(1);
    else if (dec_i && !inc_i)
      occ_d = occupancy_o - occ_t'(1);
  end

  // Flags come from the next count, in step with it.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      occupancy_o <= '0;
      full_o      <= 1'b0;
      empty_o     <= 1'b1;
    end
    else
    begin
      occupancy_o <= occ_d;
      full_o      <= (occ_d == occ_t'(`ID_REMAP_SLOTS));
      empty_o     <= (occ_d == '0);
    end
  end

endmodule

`default_nettype wire

// File: verilog/id_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_remap_defines.svh"

module id_table (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr_i,
  input  id_remap_pkg::slot_t    wr_slot_i,
  input  id_remap_pkg::orig_id_t wr_id_i,
  input  id_remap_pkg::slot_t    rd_slot_i,
  output id_remap_pkg::orig_id_t rd_id_o
);

  import id_remap_pkg::*;

  orig_id_t mem_q [`ID_REMAP_SLOTS];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `ID_REMAP_SLOTS; i++)
      begin
        mem_q[i] <= '0;
      end
    end
    else if (wr_i)
    begin
      mem_q[wr_slot_i] <= wr_id_i;
    end
  end

  // Lookup for the release path, no latency.
  assign rd_id_o = mem_q[rd_slot_i];

endmodule

`default_nettype wire

// File: verilog/id_remap_top.sv
`timescale 1ns/1ps
`default_nettype none

module id_remap_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // Allocation side.
  input  logic                   alloc_req_i,
  input  id_remap_pkg::orig_id_t alloc_id_i,
  output logic                   alloc_ack_o,
  output id_remap_pkg::slot_t    alloc_slot_o,
  // Release side.
  input  logic                   release_i,
  input  id_remap_pkg::slot_t    release_slot_i,
  output id_remap_pkg::orig_id_t release_orig_id_o,
  // Status.
  output logic                   full_o,
  output logic                   empty_o,
  output id_remap_pkg::occ_t     occupancy_o
);

  import id_remap_pkg::*;

  logic  grant;
  slot_t free_slot;
  logic  release_hit;
  logic  release_dec;

  // Only a release of a live slot lowers the count.
  assign release_dec = release_i && release_hit;

  slot_alloc_fsm slot_alloc_fsm_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc_req_i  (alloc_req_i),
    .full_i       (full_o),
    .free_slot_i  (free_slot),
    .grant_o      (grant),
    .alloc_ack_o  (alloc_ack_o),
    .alloc_slot_o (alloc_slot_o)
  );

  slot_bitmap slot_bitmap_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .set_i          (grant),
    .set_slot_i     (free_slot),
    .release_i      (release_i),
    .release_slot_i (release_slot_i),
    .free_slot_o    (free_slot),
    .release_hit_o  (release_hit)
  );

  occupancy_counter occupancy_counter_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .inc_i       (grant),
    .dec_i       (release_dec),
    .occupancy_o (occupancy_o),
    .full_o      (full_o),
    .empty_o     (empty_o)
  );

  id_table id_table_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_i      (grant),
    .wr_slot_i (free_slot),
    .wr_id_i   (alloc_id_i),
    .rd_slot_i (release_slot_i),
    .rd_id_o   (release_orig_id_o)
  );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o
);

  localparam time HALF_PERIOD = 2ns;  // 4 ns clock.

  initial
  begin
    clk_o = 1'b0;
    forever
      #(HALF_PERIOD) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: bench/id_remap_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module id_remap_asserts (
  input logic clk,
  input logic rst_n,
  input logic alloc_req_i,
  input logic alloc_ack_o,
  input logic full_o,
  input logic empty_o
);

  int fail_count = 0;

  // Fall is sampled two edges after the request was low.
  ack_fall_after_req_low: assert property (
    @(posedge clk) disable iff (!rst_n)
      $fell(alloc_ack_o) |-> !$past(alloc_req_i, 2))
    else
    begin
      $error("alloc_ack_o fell while alloc_req_i was still high");
      fail_count++;
    end

  ack_rise_not_full: assert property (
    @(posedge clk) disable iff (!rst_n)
      $rose(alloc_ack_o) |-> !$past(full_o))
    else
    begin
      $error("alloc_ack_o rose although full_o was high");
      fail_count++;
    end

  full_empty_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
      !(full_o && empty_o))
    else
    begin
      $error("full_o and empty_o high together");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: bench/id_remap_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "id_remap_defines.svh"

module id_remap_tb;

  logic                        clk;
  logic                        rst_n;
  logic                        alloc_req_i;
  logic [`ID_REMAP_ORIG_W-1:0] alloc_id_i;
  logic                        alloc_ack_o;
  logic [`ID_REMAP_SLOT_W-1:0] alloc_slot_o;
  logic                        release_i;
  logic [`ID_REMAP_SLOT_W-1:0] release_slot_i;
  logic [`ID_REMAP_ORIG_W-1:0] release_orig_id_o;
  logic                        full_o;
  logic                        empty_o;
  logic [`ID_REMAP_OCC_W-1:0]  occupancy_o;

  int          checks;
  int          errors;
  int          tests;
  int          errors_base;
  int          checks_base;
  logic [31:0] rng;
  int          fill_ids [`ID_REMAP_SLOTS];

  tb_clock_gen clock_gen_inst (
    .clk_o (clk)
  );

  id_remap_top id_remap_top_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .alloc_req_i       (alloc_req_i),
    .alloc_id_i        (alloc_id_i),
    .alloc_ack_o       (alloc_ack_o),
    .alloc_slot_o      (alloc_slot_o),
    .release_i         (release_i),
    .release_slot_i    (release_slot_i),
    .release_orig_id_o (release_orig_id_o),
    .full_o            (full_o),
    .empty_o           (empty_o),
    .occupancy_o       (occupancy_o)
  );

  bind id_remap_top id_remap_asserts id_remap_asserts_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .alloc_req_i (alloc_req_i),
    .alloc_ack_o (alloc_ack_o),
    .full_o      (full_o),
    .empty_o     (empty_o)
  );

  // ******************************
  // Helpers
  // ******************************

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string what, input int got, input int exp);
    checks++;
    assert (got == exp)
    else
    begin
      $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("Run stopped at %0t ns: %s", $time, why);
    $display("FAIL: see errors above");
    $finish;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("%s: %0d checks, %0d errors", name, checks - checks_base, errors - errors_base);
    checks_base = checks;
    errors_base = errors;
  endtask

  // Called just after a falling edge, as are all tasks below.
  task automatic wait_ack(input int limit, output bit seen);
    int cycles;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < limit)
    begin
      @(negedge clk);
      cycles++;
      seen = alloc_ack_o;
    end
  endtask

  task automatic req_finish();
    int cycles;
    alloc_req_i = 1'b0;
    cycles      = 0;
    while (alloc_ack_o && cycles < 20)
    begin
      @(negedge clk);
      cycles++;
    end
    if (alloc_ack_o)
      abort_run("alloc_ack_o never fell after the request dropped");
  endtask

  task automatic alloc_expect(input int id, input int exp_slot);
    bit seen;
    alloc_id_i  = id[`ID_REMAP_ORIG_W-1:0];
    alloc_req_i = 1'b1;
    wait_ack(20, seen);
    if (!seen)
      abort_run("no acknowledge for an allocation request");
    check_value("allocated slot", int'(alloc_slot_o), exp_slot);
    req_finish();
  endtask

  task automatic release_expect(input int slot, input int exp_id, input int exp_occ);
    release_i      = 1'b1;
    release_slot_i = slot[`ID_REMAP_SLOT_W-1:0];
    @(negedge clk);
    check_value("released original ID", int'(release_orig_id_o), exp_id);
    check_value("occupancy after release", int'(occupancy_o), exp_occ);
    release_i = 1'b0;
  endtask

  task automatic replay_vectors();
    int    fd;
    int    code;
    int    v1;
    int    v2;
    int    v3;
    string line;
    fd = $fopen("bench/id_remap_vectors.txt", "r");
    if (fd == 0)
      abort_run("cannot open bench/id_remap_vectors.txt");
    while (!$feof(fd))
    begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 0)
      begin
        if (line[0] == "A")
        begin
          code = $sscanf(line, "A %h %d", v1, v2);
          alloc_expect(v1, v2);
        end
        else if (line[0] == "R")
        begin
          code = $sscanf(line, "R %d %h %d", v1, v2, v3);
          release_expect(v1, v2, v3);
        end
      end
    end
    $fclose(fd);
  endtask

  // ******************************
  // Test sequence
  // ******************************

  initial
  begin
    int  occ;
    int  id;
    int  asrt_fails;
    bit  seen;
    checks         = 0;
    errors         = 0;
    tests          = 0;
    errors_base    = 0;
    checks_base    = 0;
    rng            = 32'd83375;
    rst_n          = 1'b0;
    alloc_req_i    = 1'b0;
    alloc_id_i     = '0;
    release_i      = 1'b0;
    release_slot_i = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check_value("empty_o after reset", int'(empty_o), 1);
    check_value("full_o after reset", int'(full_o), 0);
    check_value("occupancy_o after reset", int'(occupancy_o), 0);
    check_value("alloc_ack_o after reset", int'(alloc_ack_o), 0);
    end_test("reset state");

    replay_vectors();
    end_test("vector replay");

    // Freed slot 1 sits below live slot 2.
    alloc_expect('h11, 0);
    alloc_expect('h22, 1);
    alloc_expect('h33, 2);
    release_expect(1, 'h22, 2);
    alloc_expect('h44, 1);
    release_expect(0, 'h11, 2);
    release_expect(1, 'h44, 1);
    release_expect(2, 'h33, 0);
    end_test("slot reuse");

    for (int i = 0; i < `ID_REMAP_SLOTS; i++)
    begin
      rng         = lcg_next(rng);
      fill_ids[i] = int'(rng[23:16]);
      alloc_expect(fill_ids[i], i);
    end
    check_value("full_o after fill", int'(full_o), 1);
    check_value("occupancy_o after fill", int'(occupancy_o), `ID_REMAP_SLOTS);
    rng         = lcg_next(rng);
    id          = int'(rng[23:16]);
    alloc_id_i  = id[`ID_REMAP_ORIG_W-1:0];
    alloc_req_i = 1'b1;
    wait_ack(20, seen);
    check_value("ack while full", int'(seen), 0);
    release_expect(37, fill_ids[37], `ID_REMAP_SLOTS - 1);
    wait_ack(20, seen);
    if (!seen)
      abort_run("pending request not acknowledged after a release");
    check_value("slot after back-pressure", int'(alloc_slot_o), 37);
    req_finish();
    fill_ids[37] = id;
    check_value("full_o after refill", int'(full_o), 1);
    end_test("fill and back-pressure");

    occ = `ID_REMAP_SLOTS;
    for (int i = 0; i < `ID_REMAP_SLOTS; i++)
    begin
      occ--;
      release_expect(i, fill_ids[i], occ);
    end
    check_value("empty_o after draining", int'(empty_o), 1);
    release_i      = 1'b1;  // Every slot is free now.
    release_slot_i = 6'd10;
    @(negedge clk);
    release_i = 1'b0;
    check_value("occupancy_o after stale release", int'(occupancy_o), 0);
    check_value("full_o after stale release", int'(full_o), 0);
    check_value("empty_o after stale release", int'(empty_o), 1);
    end_test("stale release and drain");

    asrt_fails = id_remap_top_inst.id_remap_asserts_inst.fail_count;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, checks, errors, asrt_fails);
    if (errors == 0 && asrt_fails == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/id_remap_vectors.txt
# A <original ID, hex> <expected slot, decimal>
# R <slot, decimal> <expected original ID, hex> <expected occupancy after release, decimal>
A 3c 0
A 51 1
A a7 2
A 0e 3
R 1 51 3
A 92 1
R 0 3c 3
R 2 a7 2
A 44 0
A 6b 2
A f0 4
R 3 0e 4
R 1 92 3
A 17 1
R 4 f0 3
R 0 44 2
R 2 6b 1
R 1 17 0

// File: flist.f
+incdir+include
verilog/id_remap_pkg.sv
verilog/slot_alloc_fsm.sv
verilog/slot_bitmap.sv
verilog/occupancy_counter.sv
verilog/id_table.sv
verilog/id_remap_top.sv
bench/tb_clock_gen.sv
bench/id_remap_asserts.sv
bench/id_remap_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module id_remap_tb -o id_remap_sim

sim_out=$(./obj_dir/id_remap_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "PASS: all tests"; then
  exit 0
else
  exit 1
fi
